// ==== common/math_macros.svh ====
////////////////////////////////////////////////////////////////////////////
// default sizing for the chunked ALU, include where defaults are needed
////////////////////////////////////////////////////////////////////////////

`ifndef MATH_MACROS_SVH
`define MATH_MACROS_SVH

// operand width in bits
`define MATH_WIDTH 16

// clocks from operand sample to result, one chunk resolved per clock
// must be 1 or more
`define MATH_LATENCY 3

`endif

// ==== common/math_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared chunk planning functions and compare state for the chunked ALU
// import inside a module body to size the per-stage chunks
////////////////////////////////////////////////////////////////////////////

package math_pkg;

    // width of one chunk, rounded up so LATENCY chunks always cover WIDTH
    function automatic int f_chunk_width(int width, int latency);
        return (width + latency - 1) / latency;
    endfunction

    // number of chunks needed to cover the width, never above latency
    function automatic int f_chunk_count(int width, int latency);
        int cw;
        cw = f_chunk_width(width, latency);
        return (width + cw - 1) / cw;
    endfunction

    // top chunk takes whatever bits are left over, may be narrower
    function automatic int f_last_chunk_width(int width, int latency);
        int cw;
        int cn;
        cw = f_chunk_width(width, latency);
        cn = f_chunk_count(width, latency);
        return width - (cn - 1) * cw;
    endfunction

    // running compare state carried down the compare pipeline
    //   eq   : every chunk checked so far matched
    //   done : live set, stays clear in every slot flushed by reset
    typedef struct packed {
        logic eq;
        logic done;
    } cmp_state_t;

endpackage

// ==== chunk_pipe/stage_delay.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// resettable shift line for any payload type, every stage exposed as a tap
// taps[i] holds the payload sampled i+1 clocks ago
////////////////////////////////////////////////////////////////////////////

module stage_delay #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t taps [DEPTH]
);

    always_ff @(posedge clk) begin
        if (rst) begin
            // flush the whole line so no stale operands leak out
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            // first tap samples the input
            taps[0] <= din;
            // remaining taps shift by one stage per clock
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

endmodule

// ==== chunk_pipe/chunk_add_sub.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// pipelined ripple adder and subtractor, one chunk resolved per stage
// sum = a + b, diff = a - b, both modulo 2^WIDTH, LATENCY clocks later
////////////////////////////////////////////////////////////////////////////

module chunk_add_sub #(
    parameter int WIDTH   = 16,
    parameter int LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum,
    output logic [WIDTH-1:0] diff
);
    import math_pkg::*;

    // chunk plan
    localparam int CW = f_chunk_width(WIDTH, LATENCY);
    localparam int CN = f_chunk_count(WIDTH, LATENCY);
    localparam int LW = f_last_chunk_width(WIDTH, LATENCY);

    typedef struct packed {
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
    } ab_pair_t;

    ab_pair_t         ops_in;
    ab_pair_t         ops_tap [LATENCY];

    // partial results, stage k holds chunks 0..k of its own operand set
    logic [WIDTH-1:0] sum_d   [LATENCY];
    logic [WIDTH-1:0] sum_q   [LATENCY];
    logic [WIDTH-1:0] diff_d  [LATENCY];
    logic [WIDTH-1:0] diff_q  [LATENCY];

    // carry and borrow out of each chunk, top one is dropped
    logic [CN-1:0]    carry_d;
    logic [CN-1:0]    carry_q;
    logic [CN-1:0]    borrow_d;
    logic [CN-1:0]    borrow_q;

    ////////////////////////////////////////////////////////////////////////////
    // operand line
    ////////////////////////////////////////////////////////////////////////////

    assign ops_in = {a, b};

    // stage k reads the operands that entered k clocks earlier
    stage_delay #(
        .payload_t (ab_pair_t),
        .DEPTH     (LATENCY)
    ) u_ops (
        .clk  (clk),
        .rst  (rst),
        .din  (ops_in),
        .taps (ops_tap)
    );

    ////////////////////////////////////////////////////////////////////////////
    // per-stage chunk logic
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < LATENCY; k++) begin : g_stage
        if (k < CN) begin : g_chunk
            // top chunk may be narrower than the rest
            localparam int W  = (k == CN - 1) ? LW : CW;
            localparam int LO = k * CW;

            ab_pair_t         ops;
            logic [WIDTH-1:0] sum_prev;
            logic [WIDTH-1:0] diff_prev;
            logic             cin;
            logic             bin;
            logic [W:0]       add_res;
            logic [W:0]       sub_res;

            if (k == 0) begin : g_first
                // chunk 0 works straight off the inputs, nothing to ripple in
                assign ops       = ops_in;
                assign sum_prev  = '0;
                assign diff_prev = '0;
                assign cin       = 1'b0;
                assign bin       = 1'b0;
            end else begin : g_next
                assign ops       = ops_tap[k-1];
                assign sum_prev  = sum_q[k-1];
                assign diff_prev = diff_q[k-1];
                assign cin       = carry_q[k-1];
                assign bin       = borrow_q[k-1];
            end

            // extra msb catches carry out, or borrow when the result wraps
            assign add_res = {1'b0, ops.a[LO +: W]} + {1'b0, ops.b[LO +: W]}
                           + {{W{1'b0}}, cin};
            assign sub_res = {1'b0, ops.a[LO +: W]} - {1'b0, ops.b[LO +: W]}
                           - {{W{1'b0}}, bin};

            // bits above this chunk are still zero, so or merges the chunk in
            assign sum_d[k]    = sum_prev | (WIDTH'(add_res[W-1:0]) << LO);
            assign diff_d[k]   = diff_prev | (WIDTH'(sub_res[W-1:0]) << LO);
            assign carry_d[k]  = add_res[W];
            assign borrow_d[k] = sub_res[W];
        end else begin : g_pass
            // all chunks resolved, just hold the result until the output stage
            assign sum_d[k]  = sum_q[k-1];
            assign diff_d[k] = diff_q[k-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < LATENCY; k++) begin
                sum_q[k]  <= '0;
                diff_q[k] <= '0;
            end
            carry_q  <= '0;
            borrow_q <= '0;
        end else begin
            sum_q    <= sum_d;
            diff_q   <= diff_d;
            carry_q  <= carry_d;
            borrow_q <= borrow_d;
        end
    end

    // final stage holds the finished result
    assign sum  = sum_q[LATENCY-1];
    assign diff = diff_q[LATENCY-1];

endmodule

// ==== chunk_pipe/chunk_compare.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// pipelined chunked equality compare of a and c, one chunk per stage
// cmp_eq and cmp_neq come out of the last stage LATENCY clocks later
////////////////////////////////////////////////////////////////////////////

module chunk_compare #(
    parameter int WIDTH   = 16,
    parameter int LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] c,
    output logic             cmp_eq,
    output logic             cmp_neq
);
    import math_pkg::*;

    localparam int CW = f_chunk_width(WIDTH, LATENCY);
    localparam int CN = f_chunk_count(WIDTH, LATENCY);
    localparam int LW = f_last_chunk_width(WIDTH, LATENCY);

    typedef struct packed {
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] c;
    } ac_pair_t;

    ac_pair_t   ops_in;
    ac_pair_t   ops_tap [LATENCY];
    cmp_state_t state_d [LATENCY];
    cmp_state_t state_q [LATENCY];
    logic       neq_q;

    assign ops_in = {a, c};

    stage_delay #(
        .payload_t (ac_pair_t),
        .DEPTH     (LATENCY)
    ) u_ops (
        .clk  (clk),
        .rst  (rst),
        .din  (ops_in),
        .taps (ops_tap)
    );

    for (genvar k = 0; k < LATENCY; k++) begin : g_stage
        cmp_state_t prev;
        logic       chunk_eq;

        // first stage starts a live set from "all equal so far"
        if (k == 0) begin : g_first
            assign prev = '{eq: 1'b1, done: 1'b1};
        end else begin : g_next
            assign prev = state_q[k-1];
        end

        if (k < CN) begin : g_chunk
            localparam int W  = (k == CN - 1) ? LW : CW;
            localparam int LO = k * CW;

            ac_pair_t ops;

            if (k == 0) begin : g_src_in
                assign ops = ops_in;
            end else begin : g_src_tap
                assign ops = ops_tap[k-1];
            end
            assign chunk_eq = (ops.a[LO +: W] == ops.c[LO +: W]);
        end else begin : g_pass
            assign chunk_eq = 1'b1;
        end

        // done rides along with its set, a slot flushed by reset never gets it
        assign state_d[k] = '{eq: prev.eq & chunk_eq, done: prev.done};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < LATENCY; k++) begin
                state_q[k] <= '0;
            end
            neq_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // neq taken from the same state as eq, on the same edge
            neq_q   <= state_d[LATENCY-1].done & ~state_d[LATENCY-1].eq;
        end
    end

    // both flags stay low until a finished state reaches the end
    assign cmp_eq  = state_q[LATENCY-1].eq & state_q[LATENCY-1].done;
    assign cmp_neq = neq_q;

endmodule

// ==== verilog/math_alu_top.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// chunked ALU top, a + b and a - b plus a == c, fixed LATENCY clocks
// a new operand set can be applied on every rising edge
////////////////////////////////////////////////////////////////////////////

`include "math_macros.svh"

module math_alu_top #(
    parameter int WIDTH   = `MATH_WIDTH,
    parameter int LATENCY = `MATH_LATENCY
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] c,
    output logic [WIDTH-1:0] sum,
    output logic [WIDTH-1:0] diff,
    output logic             cmp_eq,
    output logic             cmp_neq
);
    import math_pkg::*;

    // elaboration guard on the sizing
    if (LATENCY < 1) begin : g_bad_latency
        $error("math_alu_top: LATENCY must be at least 1");
    end else if (f_chunk_count(WIDTH, LATENCY) > LATENCY) begin : g_bad_chunks
        $error("math_alu_top: chunk count exceeds LATENCY");
    end

    ////////////////////////////////////////////////////////////////////////////
    // arithmetic pipeline, a and b
    ////////////////////////////////////////////////////////////////////////////

    chunk_add_sub #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) u_add_sub (
        .clk  (clk),
        .rst  (rst),
        .a    (a),
        .b    (b),
        .sum  (sum),
        .diff (diff)
    );

    ////////////////////////////////////////////////////////////////////////////
    // compare pipeline, a and c
    ////////////////////////////////////////////////////////////////////////////

    chunk_compare #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) u_compare (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .c       (c),
        .cmp_eq  (cmp_eq),
        .cmp_neq (cmp_neq)
    );

endmodule

// ==== tb/math_alu_chk.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// reset window and compare flag properties, bound onto the ALU top
////////////////////////////////////////////////////////////////////////////

module math_alu_chk #(
    parameter int WIDTH   = 16,
    parameter int LATENCY = 3
) (
    input logic             clk,
    input logic             rst,
    input logic [WIDTH-1:0] sum,
    input logic [WIDTH-1:0] diff,
    input logic             cmp_eq,
    input logic             cmp_neq
);
    import math_pkg::*;

    // edges since the last reset edge, saturates at LATENCY
    int         since_rst = LATENCY;
    logic       seen_rst  = 1'b0;
    // assertion failures so far
    int         fail_count = 0;
    // output flags seen as a compare state, done means a verdict is out
    cmp_state_t out_state;

    assign out_state = '{eq: cmp_eq, done: cmp_eq | cmp_neq};

    always @(posedge clk) begin
        if (rst) begin
            seen_rst  <= 1'b1;
            since_rst <= 0;
        end else if (since_rst < LATENCY) begin
            since_rst <= since_rst + 1;
        end
    end

    // nothing comes out until the refilled pipeline reaches the end
    a_reset_zero: assert property (@(posedge clk)
        (seen_rst && since_rst < LATENCY) |->
            (sum == '0 && diff == '0 && !out_state.eq && !out_state.done))
        else begin
            $error("outputs not zero inside the reset window");
            fail_count++;
        end

    // neq is the inverse of eq once results flow
    a_complement: assert property (@(posedge clk)
        (seen_rst && since_rst >= LATENCY) |-> (cmp_neq == !cmp_eq))
        else begin
            $error("cmp_neq is not the inverse of cmp_eq");
            fail_count++;
        end

    a_known: assert property (@(posedge clk)
        seen_rst |-> !$isunknown({sum, diff, cmp_eq, cmp_neq}))
        else begin
            $error("unknown value on an ALU output after reset");
            fail_count++;
        end

endmodule

bind math_alu_top math_alu_chk #(
    .WIDTH   (WIDTH),
    .LATENCY (LATENCY)
) u_chk (
    .clk     (clk),
    .rst     (rst),
    .sum     (sum),
    .diff    (diff),
    .cmp_eq  (cmp_eq),
    .cmp_neq (cmp_neq)
);

// ==== tb/math_alu_monitor.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// reference model and scoreboard for the chunked ALU
// queues full width results per edge, compares them LATENCY edges later
////////////////////////////////////////////////////////////////////////////

module math_alu_monitor #(
    parameter int WIDTH   = 16,
    parameter int LATENCY = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic [WIDTH-1:0] c,
    input  int               test_id,
    input  logic [WIDTH-1:0] sum,
    input  logic [WIDTH-1:0] diff,
    input  logic             cmp_eq,
    input  logic             cmp_neq,
    output int               sum_errors,
    output int               diff_errors,
    output int               cmp_errors,
    output int               check_count
);

    // one entry per sampled set, oldest at the front
    logic [WIDTH-1:0] exp_sum  [$];
    logic [WIDTH-1:0] exp_diff [$];
    logic             exp_eq   [$];
    logic             exp_neq  [$];
    int               exp_test [$];

    initial begin
        sum_errors  = 0;
        diff_errors = 0;
        cmp_errors  = 0;
        check_count = 0;
    end

    function automatic string test_name(int id);
        case (id)
            0:       return "reset";
            1:       return "random_add_sub";
            2:       return "carry_borrow";
            3:       return "equality";
            4:       return "near_miss";
            5:       return "drain";
            default: return "unknown";
        endcase
    endfunction

    // inputs and outputs read here hold their pre-edge values
    always @(posedge clk) begin
        logic [WIDTH-1:0] e_sum;
        logic [WIDTH-1:0] e_diff;
        logic             e_eq;
        logic             e_neq;
        string            name;
        // set sampled LATENCY edges ago is due now
        if (exp_sum.size() == LATENCY) begin
            e_sum  = exp_sum.pop_front();
            e_diff = exp_diff.pop_front();
            e_eq   = exp_eq.pop_front();
            e_neq  = exp_neq.pop_front();
            name   = test_name(exp_test.pop_front());
            check_count = check_count + 1;
            if (sum !== e_sum) begin
                sum_errors = sum_errors + 1;
                $display("Error: %s sum expected %h actual %h", name, e_sum, sum);
            end
            if (diff !== e_diff) begin
                diff_errors = diff_errors + 1;
                $display("Error: %s diff expected %h actual %h", name, e_diff, diff);
            end
            if (cmp_eq !== e_eq || cmp_neq !== e_neq) begin
                cmp_errors = cmp_errors + 1;
                $display("Error: %s cmp_eq/cmp_neq expected %b/%b actual %b/%b",
                         name, e_eq, e_neq, cmp_eq, cmp_neq);
            end
        end
        // a reset edge flushes its stage, so that slot comes out all zero
        exp_sum.push_back(rst ? '0 : a + b);
        exp_diff.push_back(rst ? '0 : a - b);
        exp_eq.push_back(!rst && (a == c));
        exp_neq.push_back(!rst && (a != c));
        exp_test.push_back(test_id);
    end

endmodule

// ==== tb/math_alu_tb.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// testbench for the chunked ALU, seeded random and directed operand sets
// results are compared by the monitor, properties by the bound checker
////////////////////////////////////////////////////////////////////////////

`include "math_macros.svh"

module math_alu_tb;

    localparam int WIDTH       = `MATH_WIDTH;
    localparam int LATENCY     = `MATH_LATENCY;
    localparam int RST_CYCLES  = 16;
    localparam int N_RANDOM    = 500;
    localparam int N_CARRY     = 4 + 2 * WIDTH;
    localparam int N_EQUAL     = 200;
    localparam int N_MISS      = WIDTH;
    localparam int STIM_CYCLES = N_RANDOM + N_CARRY + N_EQUAL + N_MISS;
    // reset, stimulus, pipeline drain and some slack
    localparam int MAX_CYCLES  = RST_CYCLES + STIM_CYCLES + LATENCY + 20;

    // test ids, the monitor turns them into names
    localparam int T_RESET  = 0;
    localparam int T_RANDOM = 1;
    localparam int T_CARRY  = 2;
    localparam int T_EQUAL  = 3;
    localparam int T_MISS   = 4;
    localparam int T_DRAIN  = 5;

    logic             clk;
    logic             rst;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] c;
    logic [WIDTH-1:0] sum;
    logic [WIDTH-1:0] diff;
    logic             cmp_eq;
    logic             cmp_neq;
    int               test_id;
    int               seed;
    int               cycle_count;
    int               sum_errors;
    int               diff_errors;
    int               cmp_errors;
    int               check_count;

    always #4 clk = ~clk;

    math_alu_top #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .b       (b),
        .c       (c),
        .sum     (sum),
        .diff    (diff),
        .cmp_eq  (cmp_eq),
        .cmp_neq (cmp_neq)
    );

    math_alu_monitor #(
        .WIDTH   (WIDTH),
        .LATENCY (LATENCY)
    ) u_monitor (
        .clk         (clk),
        .rst         (rst),
        .a           (a),
        .b           (b),
        .c           (c),
        .test_id     (test_id),
        .sum         (sum),
        .diff        (diff),
        .cmp_eq      (cmp_eq),
        .cmp_neq     (cmp_neq),
        .sum_errors  (sum_errors),
        .diff_errors (diff_errors),
        .cmp_errors  (cmp_errors),
        .check_count (check_count)
    );

    // two draws so wider operands still get random upper bits
    function automatic logic [WIDTH-1:0] rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return WIDTH'(r);
    endfunction

    // one operand set per rising edge
    task automatic apply_set(input logic [WIDTH-1:0] na, input logic [WIDTH-1:0] nb,
                             input logic [WIDTH-1:0] nc, input int id);
        @(posedge clk);
        a       <= na;
        b       <= nb;
        c       <= nc;
        test_id <= id;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // run limit
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [WIDTH-1:0] na;
        logic [WIDTH-1:0] nc;
        logic [WIDTH-1:0] ones;
        int               total_errors;
        clk         = 1'b0;
        rst         = 1'b1;
        a           = '0;
        b           = '0;
        c           = '0;
        test_id     = T_RESET;
        seed        = 32'h7a02_8eca;
        cycle_count = 0;
        ones        = '1;

        // operands keep moving during reset, the pipeline must ignore them
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk);
            a <= rand_word();
            b <= rand_word();
            c <= rand_word();
            if (i == RST_CYCLES - 1) begin
                rst <= 1'b0;
            end
        end

        // back to back random sums and differences
        for (int i = 0; i < N_RANDOM; i++) begin
            apply_set(rand_word(), rand_word(), rand_word(), T_RANDOM);
        end

        // full ripple cases first
        apply_set(ones, WIDTH'(1), rand_word(), T_CARRY);
        apply_set('0, WIDTH'(1), rand_word(), T_CARRY);
        apply_set(ones, ones, rand_word(), T_CARRY);
        apply_set('0, ones, rand_word(), T_CARRY);
        // carry through the low p+1 bits, borrow down from bit p
        for (int p = 0; p < WIDTH; p++) begin
            apply_set(ones >> (WIDTH - 1 - p), WIDTH'(1), rand_word(), T_CARRY);
            apply_set(WIDTH'(1) << p, WIDTH'(1), rand_word(), T_CARRY);
        end

        // c copies a on about half the sets
        for (int i = 0; i < N_EQUAL; i++) begin
            na = rand_word();
            nc = (($random(seed) & 1) != 0) ? na : rand_word();
            apply_set(na, rand_word(), nc, T_EQUAL);
        end

        // single bit flip walks through every chunk, the top one too
        for (int i = 0; i < N_MISS; i++) begin
            na = rand_word();
            apply_set(na, rand_word(), na ^ (WIDTH'(1) << i), T_MISS);
        end

        // let the last sets reach the outputs
        repeat (LATENCY + 1) begin
            apply_set(rand_word(), rand_word(), rand_word(), T_DRAIN);
        end
        @(negedge clk);

        total_errors = sum_errors + diff_errors + cmp_errors + uut.u_chk.fail_count;
        if (check_count < STIM_CYCLES) begin
            $display("too few results were compared, %0d of at least %0d",
                     check_count, STIM_CYCLES);
            total_errors = total_errors + 1;
        end
        $display("checks %0d, errors: sum %0d, diff %0d, compare %0d, assertions %0d",
                 check_count, sum_errors, diff_errors, cmp_errors,
                 uut.u_chk.fail_count);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/math_pkg.sv
chunk_pipe/stage_delay.sv
chunk_pipe/chunk_add_sub.sv
chunk_pipe/chunk_compare.sv
verilog/math_alu_top.sv
tb/math_alu_chk.sv
tb/math_alu_monitor.sv
tb/math_alu_tb.sv

// ==== Makefile ====
# Verilator flow for the chunked ALU
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= math_alu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides the result, the simulator exit code is not trusted
sim: build
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "FAIL: failure reported in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "sim passed" $(LOG); then \
		echo "FAIL: run ended without a pass line in $(LOG)"; exit 1; \
	fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
